// File: tb.f
+incdir+include
rtl/ipv4_pkg.sv
rtl/ipv4_checksum_update.sv
rtl/ipv4_hdr_capture.sv
rtl/ipv4_hdr_emit.sv
rtl/ipv4_ttl_forward.sv
tb/ipv4_ttl_forward_tb.sv

// File: Makefile
# Verilator build and run for the IPv4 TTL forwarding rewriter.

VERILATOR ?= verilator
TOP       ?= ipv4_ttl_forward_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test FAILED, see $(LOG)"; exit 1; }
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/ipv4_tb_model.svh
/* IPv4 rewrite reference model */

`ifndef IPV4_TB_MODEL_SVH
`define IPV4_TB_MODEL_SVH

// ones'-complement addition of two words.
function automatic ipv4_pkg::hdr_word_t model_ones_add(input ipv4_pkg::hdr_word_t a,
                                                       input ipv4_pkg::hdr_word_t b);
    logic [16:0] total;
    total = {1'b0, a} + {1'b0, b};
    return total[15:0] + {15'd0, total[16]};
endfunction

// RFC 1624 equation 3 for one changed word.
function automatic ipv4_pkg::hdr_word_t model_csum_update(input ipv4_pkg::hdr_word_t hc,
                                                          input ipv4_pkg::hdr_word_t m,
                                                          input ipv4_pkg::hdr_word_t m_new);
    return ~model_ones_add(model_ones_add(~hc, ~m), m_new);
endfunction

// sum over all ten words, 16'hFFFF for a header with a valid checksum.
function automatic ipv4_pkg::hdr_word_t model_hdr_sum(
    input ipv4_pkg::hdr_word_t words [ipv4_pkg::HDR_WORDS]
);
    ipv4_pkg::hdr_word_t sum;
    sum = '0;
    for (int i = 0; i < ipv4_pkg::HDR_WORDS; i++) begin
        sum = model_ones_add(sum, words[i]);
    end
    return sum;
endfunction

// full checksum of a header, computed with the checksum field taken as zero.
function automatic ipv4_pkg::hdr_word_t model_hdr_csum(
    input ipv4_pkg::hdr_word_t words [ipv4_pkg::HDR_WORDS]
);
    ipv4_pkg::hdr_word_t tmp [ipv4_pkg::HDR_WORDS];
    tmp = words;
    tmp[ipv4_pkg::CSUM_WORD_IDX] = '0;
    return ~model_hdr_sum(tmp);
endfunction

// expected output header for a forwarded input header.
function automatic void model_rewrite(input ipv4_pkg::hdr_word_t in_words [ipv4_pkg::HDR_WORDS],
                                      input int unsigned ttl_dec,
                                      output ipv4_pkg::hdr_word_t exp_words [ipv4_pkg::HDR_WORDS]);
    ipv4_pkg::ttl_proto_u word;
    exp_words = in_words;
    word.raw = in_words[ipv4_pkg::TTL_WORD_IDX];
    word.fields.ttl = word.fields.ttl - 8'(ttl_dec);
    exp_words[ipv4_pkg::TTL_WORD_IDX] = word.raw;
    exp_words[ipv4_pkg::CSUM_WORD_IDX] = model_csum_update(in_words[ipv4_pkg::CSUM_WORD_IDX],
                                                           in_words[ipv4_pkg::TTL_WORD_IDX],
                                                           word.raw);
endfunction

`endif

// File: tb/ipv4_ttl_forward_tb.sv
/* IPv4 TTL forwarding testbench */

`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_forward_tb
    import ipv4_pkg::*;
;

    `include "ipv4_tb_model.svh"

    localparam int unsigned TTL_DEC      = 1;
    localparam int          RESET_CYCLES = 8;
    localparam int          NUM_HDRS     = 60;
    localparam int          IDLE_TIMEOUT = 100;
    localparam int          OUT_TIMEOUT  = 20;

    logic      clk;
    logic      arst_n_i;
    logic      in_valid_i;
    hdr_word_t in_word_i;
    logic      out_valid_o;
    hdr_word_t out_word_o;
    logic      out_last_o;
    logic      drop_o;
    logic      busy_o;

    integer    seed = 32'h366cc541;
    int        fwd_count;
    int        drop_count;

    ipv4_ttl_forward #(
        .TTL_DEC (TTL_DEC)
    ) uut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_word_i   (in_word_i),
        .out_valid_o (out_valid_o),
        .out_word_o  (out_word_o),
        .out_last_o  (out_last_o),
        .drop_o      (drop_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input hdr_word_t got, input hdr_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ttl(input string name, input ttl_proto_u got, input ttl_proto_u exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got ttl %h protocol %h expected ttl %h protocol %h",
                     $time, name, got.fields.ttl, got.fields.protocol,
                     exp.fields.ttl, exp.fields.protocol);
            stop_run();
        end
    endtask

    // a random header with a valid checksum; low TTLs come up often so drops are common.
    task automatic make_header(output hdr_word_t words [HDR_WORDS]);
        ttl_proto_u tp;
        for (int i = 0; i < HDR_WORDS; i++) begin
            words[i] = 16'($random(seed));
        end
        tp.raw = words[TTL_WORD_IDX];
        if (($random(seed) & 1) != 0) begin
            tp.fields.ttl = 8'($unsigned($random(seed)) % 4);
        end
        words[TTL_WORD_IDX]  = tp.raw;
        words[CSUM_WORD_IDX] = model_hdr_csum(words);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy_o) begin
            if (n == IDLE_TIMEOUT) begin
                abort_run("busy_o did not fall before the next header");
            end
            n++;
            @(negedge clk);
        end
    endtask

    // returns on the rising edge where the DUT samples word 9.
    task automatic send_words(input hdr_word_t words [HDR_WORDS]);
        int gap;
        for (int i = 0; i < HDR_WORDS; i++) begin
            gap = int'($unsigned($random(seed)) % 3);
            repeat (gap) begin
                @(posedge clk);
                in_valid_i <= 1'b0;
            end
            @(posedge clk);
            in_valid_i <= 1'b1;
            in_word_i  <= words[i];
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
    endtask

    task automatic run_header(input hdr_word_t words [HDR_WORDS]);
        ttl_proto_u in_ttl;
        ttl_proto_u exp_ttl;
        ttl_proto_u got_ttl;
        hdr_word_t  exp_words [HDR_WORDS];
        hdr_word_t  got_words [HDR_WORDS];
        logic       expired;
        int         n;
        in_ttl.raw = words[TTL_WORD_IDX];
        expired    = (32'(in_ttl.fields.ttl) <= TTL_DEC);
        wait_idle();
        send_words(words);
        n = 0;
        if (expired) begin
            do begin
                @(negedge clk);
                n++;
                check_bit("out_valid_o", out_valid_o, 1'b0);
            end while (!drop_o && n < OUT_TIMEOUT);
            if (!drop_o) begin
                abort_run("drop_o never pulsed for an expired TTL");
            end
            if (n != 1) begin
                abort_run($sformatf("drop_o came %0d cycles after the last word, not 1", n));
            end
            // one pulse only, and nothing leaves before the buffer is released.
            n = 0;
            do begin
                @(negedge clk);
                n++;
                check_bit("drop_o", drop_o, 1'b0);
                check_bit("out_valid_o", out_valid_o, 1'b0);
            end while (busy_o && n < OUT_TIMEOUT);
            if (busy_o) begin
                abort_run("busy_o stayed high after a dropped header");
            end
            drop_count++;
        end else begin
            exp_ttl            = in_ttl;
            exp_ttl.fields.ttl = in_ttl.fields.ttl - 8'(TTL_DEC);
            model_rewrite(words, TTL_DEC, exp_words);
            do begin
                @(negedge clk);
                n++;
                check_bit("drop_o", drop_o, 1'b0);
            end while (!out_valid_o && n < OUT_TIMEOUT);
            if (!out_valid_o) begin
                abort_run("no output word appeared for a forwarded header");
            end
            if (n != 4) begin
                abort_run($sformatf("first output word came %0d cycles after the last word, not 4",
                                    n));
            end
            for (int k = 0; k < HDR_WORDS; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                check_bit("out_valid_o", out_valid_o, 1'b1);
                check_bit("out_last_o", out_last_o, k == HDR_WORDS - 1);
                got_words[k] = out_word_o;
                if (k == TTL_WORD_IDX) begin
                    got_ttl.raw = out_word_o;
                    check_ttl("out_word_o ttl/protocol", got_ttl, exp_ttl);
                end else if (k == CSUM_WORD_IDX) begin
                    check_word("out_word_o checksum", out_word_o, exp_words[k]);
                end else begin
                    check_word($sformatf("out_word_o[%0d]", k), out_word_o, words[k]);
                end
            end
            @(negedge clk);
            check_bit("out_valid_o", out_valid_o, 1'b0);
            check_word("output header sum", model_hdr_sum(got_words), 16'hFFFF);
            fwd_count++;
        end
    endtask

    initial begin
        hdr_word_t known [HDR_WORDS];
        hdr_word_t words [HDR_WORDS];
        arst_n_i   = 1'b0;
        in_valid_i = 1'b0;
        in_word_i  = '0;
        fwd_count  = 0;
        drop_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("drop_o", drop_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);

        // RFC 1624 example: HC DD2F, m 5555, m' 3285 gives 0000.
        check_word("equation 3 known vector",
                   model_csum_update(16'hDD2F, 16'h5555, 16'h3285), 16'h0000);

        // a valid header carrying the same old checksum and TTL word.
        known = '{16'h4500, 16'h0000, 16'h0000, 16'h0000, 16'h5555,
                  16'hDD2F, 16'h0000, 16'h0000, 16'h0000, 16'h887A};
        check_word("known header sum", model_hdr_sum(known), 16'hFFFF);
        run_header(known);

        for (int h = 0; h < NUM_HDRS; h++) begin
            make_header(words);
            run_header(words);
        end
        wait_idle();
        $display("%0d headers forwarded, %0d dropped", fwd_count, drop_count);
        $display("Verification passed");
        $finish;
    end

endmodule : ipv4_ttl_forward_tb

`default_nettype wire

// File: rtl/ipv4_ttl_forward.sv
/* IPv4 TTL forwarding rewriter */

`timescale 1ns/1ps
`default_nettype none

module ipv4_ttl_forward
    import ipv4_pkg::*;
#(
    parameter int unsigned TTL_DEC = 1
) (
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       in_valid_i,
    input  hdr_word_t in_word_i,
    output logic      out_valid_o,
    output hdr_word_t out_word_o,
    output logic      out_last_o,
    output logic      drop_o,
    output logic      busy_o
);

    hdr_word_t hdr_words [HDR_WORDS];
    logic      update_req;
    hdr_word_t old_csum;
    hdr_word_t old_field;
    hdr_word_t new_field;
    logic      update_valid;
    hdr_word_t new_csum;
    logic      emit_done;

    ipv4_hdr_capture #(
        .TTL_DEC (TTL_DEC)
    ) u_capture (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .in_word_i    (in_word_i),
        .emit_done_i  (emit_done),
        .hdr_words_o  (hdr_words),
        .update_req_o (update_req),
        .old_csum_o   (old_csum),
        .old_field_o  (old_field),
        .new_field_o  (new_field),
        .drop_o       (drop_o),
        .busy_o       (busy_o)
    );

    ipv4_checksum_update u_csum (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .update_req_i   (update_req),
        .old_csum_i     (old_csum),
        .old_field_i    (old_field),
        .new_field_i    (new_field),
        .update_valid_o (update_valid),
        .new_csum_o     (new_csum)
    );

    // the reduced TTL word feeding the checksum is also the word emitted.
    ipv4_hdr_emit u_emit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .hdr_words_i    (hdr_words),
        .new_ttl_word_i (new_field),
        .update_valid_i (update_valid),
        .new_csum_i     (new_csum),
        .out_valid_o    (out_valid_o),
        .out_last_o     (out_last_o),
        .out_word_o     (out_word_o),
        .emit_done_o    (emit_done)
    );

endmodule : ipv4_ttl_forward

`default_nettype wire

// File: rtl/ipv4_hdr_emit.sv
/* IPv4 rewritten header output */

`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_emit
    import ipv4_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  hdr_word_t hdr_words_i [HDR_WORDS],
    input  hdr_word_t new_ttl_word_i,
    input  wire       update_valid_i,
    input  hdr_word_t new_csum_i,
    output logic      out_valid_o,
    output logic      out_last_o,
    output hdr_word_t out_word_o,
    output logic      emit_done_o
);

    localparam logic [3:0] LAST_IDX = 4'(HDR_WORDS - 1);
    localparam logic [3:0] TTL_IDX  = 4'(TTL_WORD_IDX);
    localparam logic [3:0] CSUM_IDX = 4'(CSUM_WORD_IDX);

    logic       active_q;
    logic [3:0] idx_q;
    hdr_word_t  csum_q;

    always_ff @(posedge clk) begin
        if (update_valid_i) begin
            csum_q <= new_csum_i;
        end
    end

    // the checksum result starts a ten-cycle walk over the buffer.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            idx_q    <= '0;
        end else if (update_valid_i) begin
            active_q <= 1'b1;
            idx_q    <= '0;
        end else if (active_q) begin
            if (idx_q == LAST_IDX) begin
                active_q <= 1'b0;
                idx_q    <= '0;
            end else begin
                idx_q <= idx_q + 4'd1;
            end
        end
    end

    // only the TTL word and the checksum change on the way through.
    always_comb begin
        if (idx_q == TTL_IDX) begin
            out_word_o = new_ttl_word_i;
        end else if (idx_q == CSUM_IDX) begin
            out_word_o = csum_q;
        end else begin
            out_word_o = hdr_words_i[idx_q];
        end
    end

    assign out_valid_o = active_q;
    assign out_last_o  = active_q && (idx_q == LAST_IDX);
    assign emit_done_o = out_last_o;

    // a new checksum result would cut a running burst short.
    a_no_restart_in_burst : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        update_valid_i |-> !active_q
    ) else $error("new checksum result arrived while a burst was still running.");

endmodule : ipv4_hdr_emit

`default_nettype wire

// File: rtl/ipv4_hdr_capture.sv
/* IPv4 header capture and TTL check */

`timescale 1ns/1ps
`default_nettype none

module ipv4_hdr_capture
    import ipv4_pkg::*;
#(
    parameter int unsigned TTL_DEC = 1
) (
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       in_valid_i,
    input  hdr_word_t in_word_i,
    input  wire       emit_done_i,
    output hdr_word_t hdr_words_o [HDR_WORDS],
    output logic      update_req_o,
    output hdr_word_t old_csum_o,
    output hdr_word_t old_field_o,
    output hdr_word_t new_field_o,
    output logic      drop_o,
    output logic      busy_o
);

    localparam logic [3:0] LAST_IDX  = 4'(HDR_WORDS - 1);
    localparam logic [7:0] TTL_DEC_B = 8'(TTL_DEC);

    hdr_word_t  hdr_q [HDR_WORDS];
    logic [3:0] cnt_q;
    logic       emit_wait_q;
    ttl_proto_u ttl_word;
    ttl_proto_u new_ttl_word;
    logic       ttl_expired;

    // word 4 was stored long before word 9 arrives, so the decision on
    // the last word can read it straight from the buffer.
    assign ttl_word.raw = hdr_q[TTL_WORD_IDX];
    assign ttl_expired  = ({24'd0, ttl_word.fields.ttl} <= TTL_DEC);

    always_comb begin
        new_ttl_word            = ttl_word;
        new_ttl_word.fields.ttl = ttl_word.fields.ttl - TTL_DEC_B;
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            hdr_q[cnt_q] <= in_word_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q        <= '0;
            emit_wait_q  <= 1'b0;
            update_req_o <= 1'b0;
            drop_o       <= 1'b0;
            busy_o       <= 1'b0;
        end else begin
            update_req_o <= 1'b0;
            drop_o       <= 1'b0;
            if (in_valid_i) begin
                busy_o <= 1'b1;
                if (cnt_q == LAST_IDX) begin
                    cnt_q <= '0;
                    if (ttl_expired) begin
                        drop_o <= 1'b1;
                    end else begin
                        update_req_o <= 1'b1;
                        emit_wait_q  <= 1'b1;
                    end
                end else begin
                    cnt_q <= cnt_q + 4'd1;
                end
            end
            // a dropped header frees the buffer in the drop cycle, a forwarded
            // one only when the last word has left the emitter.
            if (drop_o || emit_done_i) begin
                busy_o      <= 1'b0;
                emit_wait_q <= 1'b0;
            end
        end
    end

    // the buffer stays stable while emit reads it.
    assign hdr_words_o = hdr_q;
    assign old_csum_o  = hdr_q[CSUM_WORD_IDX];
    assign old_field_o = ttl_word.raw;
    assign new_field_o = new_ttl_word.raw;

    // the source must hold off while a header is still being dropped or emitted.
    a_no_input_while_held : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (emit_wait_q || drop_o) |-> !in_valid_i
    ) else $error("input word strobed while the previous header is still held.");

endmodule : ipv4_hdr_capture

`default_nettype wire

// File: rtl/ipv4_checksum_update.sv
/* RFC 1624 incremental checksum update */

`timescale 1ns/1ps
`default_nettype none

module ipv4_checksum_update
    import ipv4_pkg::*;
(
    input  wire       clk,
    input  wire       arst_n_i,
    input  wire       update_req_i,
    input  hdr_word_t old_csum_i,
    input  hdr_word_t old_field_i,
    input  hdr_word_t new_field_i,
    output logic      update_valid_o,
    output hdr_word_t new_csum_o
);

    // ones'-complement addition with the carry folded back in.
    function automatic hdr_word_t ones_add(input hdr_word_t a, input hdr_word_t b);
        logic [16:0] total;
        total = {1'b0, a} + {1'b0, b};
        return total[15:0] + {15'd0, total[16]};
    endfunction

    logic      valid_s1_q;
    hdr_word_t sum_s1_q;
    hdr_word_t new_field_s1_q;

    // equation 3 is HC' = ~(~HC + ~m + m'); stage one forms ~HC + ~m.
    always_ff @(posedge clk) begin
        sum_s1_q       <= ones_add(~old_csum_i, ~old_field_i);
        new_field_s1_q <= new_field_i;
    end

    // stage two adds m' and complements.
    always_ff @(posedge clk) begin
        new_csum_o <= ~ones_add(sum_s1_q, new_field_s1_q);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_s1_q     <= 1'b0;
            update_valid_o <= 1'b0;
        end else begin
            valid_s1_q     <= update_req_i;
            update_valid_o <= valid_s1_q;
        end
    end

    // equation 3 never turns a checksum other than FFFF into the negative zero FFFF,
    // and the result comes back exactly two cycles after its request.
    a_no_negative_zero : assert property (
        @(posedge clk) disable iff (!arst_n_i)
        update_req_i && (old_csum_i != 16'hFFFF)
            |-> ##2 (update_valid_o && (new_csum_o != 16'hFFFF))
    ) else $error("checksum result missing or negative zero two cycles after its request.");

endmodule : ipv4_checksum_update

`default_nettype wire

// File: rtl/ipv4_pkg.sv
/* IPv4 forwarding shared definitions */

`default_nettype none

package ipv4_pkg;

    // an option-less IPv4 header is twenty bytes, carried as ten 16-bit words.
    localparam int HDR_WORDS = 10;

    // word 4 holds TTL in its upper byte and protocol in its lower byte.
    localparam int TTL_WORD_IDX = 4;

    // word 5 is the header checksum.
    localparam int CSUM_WORD_IDX = 5;

    typedef logic [15:0] hdr_word_t;

    // the TTL/protocol word is used whole by the checksum arithmetic and
    // split into its two bytes by the TTL decrement.
    typedef struct packed {
        logic [7:0] ttl;
        logic [7:0] protocol;
    } ttl_proto_fields_t;

    typedef union packed {
        hdr_word_t         raw;
        ttl_proto_fields_t fields;
    } ttl_proto_u;

endpackage : ipv4_pkg

`default_nettype wire
